// ==== sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  // control word layout, type field sits at the top
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int CTRL_WIDTH     = 36;

  // slot number or slot count field
  localparam int SLOT_FIELD_LSB = 16;

  // slot part of a destination tag is never narrower than this
  localparam int TAG_MIN_WIDTH  = 5;

  typedef logic [CTRL_WIDTH-1:0]     ctrl_word_t;
  typedef logic [MSG_TYPE_WIDTH-1:0] msg_type_t;

  // message codes handled by the scheduler
  localparam msg_type_t MSG_SLOT_RETURN = 4'd0;
  localparam msg_type_t MSG_SLOT_LOAD   = 4'd3;

endpackage

`default_nettype wire

// ==== sched_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// slot returned by a core, queued in msg_intake
interface slot_ret_if #(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_WIDTH    = 4
);
  logic                     valid;
  logic [CORE_ID_WIDTH-1:0] core;
  logic [SLOT_WIDTH-1:0]    slot;
  logic                     ready;

  modport source (output valid, output core, output slot, input ready);
  modport sink (input valid, input core, input slot, output ready);
endinterface

// request to reload a core's slot queue
interface load_req_if #(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_WIDTH    = 4
);
  logic                     valid;
  logic [CORE_ID_WIDTH-1:0] core;
  logic [SLOT_WIDTH-1:0]    count;
  logic                     ready;

  modport source (output valid, output core, output count, input ready);
  modport sink (input valid, input core, input count, output ready);
endinterface

// loader strobes, no back-pressure
interface load_if #(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_WIDTH    = 4
);
  logic                     clear;
  logic                     load;
  logic [CORE_ID_WIDTH-1:0] core;
  logic [SLOT_WIDTH-1:0]    slot;

  modport source (output clear, output load, output core, output slot);
  modport sink (input clear, input load, input core, input slot);
endinterface

// head of the selected core's queue
interface desc_if #(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_WIDTH    = 4
);
  logic                     valid;
  logic [CORE_ID_WIDTH-1:0] core;
  logic [SLOT_WIDTH-1:0]    slot;
  logic                     pop;

  modport source (output valid, output core, output slot, input pop);
  modport sink (input valid, input core, input slot, output pop);
endinterface

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DEPTH_LOG2 = 3,
  parameter int WIDTH      = 8,
  localparam int DEPTH     = 1 << DEPTH_LOG2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,

  input  logic [WIDTH-1:0]      in_data,
  input  logic                  in_valid,
  output logic                  in_ready,

  output logic [WIDTH-1:0]      out_data,
  output logic                  out_valid,
  input  logic                  out_ready,

  output logic [DEPTH_LOG2:0]   count
);

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   fill;
  logic                  push;
  logic                  pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign in_ready  = (fill != (DEPTH_LOG2 + 1)'(DEPTH));
  assign out_valid = (fill != '0);
  assign out_data  = mem[rd_ptr];
  assign count     = fill;

  // clear wins over a push or pop in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        fill <= fill + 1'b1;
      else if (pop && !push)
        fill <= fill - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

// ==== msg_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_intake #(
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT)
) (
  input  logic                     clk,
  input  logic                     rst,

  input  sched_pkg::ctrl_word_t    ctrl_tdata,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_tuser,
  input  logic                     ctrl_tvalid,
  output logic                     ctrl_tready,

  slot_ret_if.source               ret,
  load_req_if.source               req
);

  import sched_pkg::*;

  msg_type_t                           msg_type;
  logic [SLOT_WIDTH-1:0]               field;
  logic                                is_ret;
  logic                                is_load;
  logic                                ret_in_ready;
  logic                                load_free;
  logic [CORE_ID_WIDTH+SLOT_WIDTH-1:0] ret_word;

  assign msg_type = ctrl_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH];
  assign field    = ctrl_tdata[SLOT_FIELD_LSB +: SLOT_WIDTH];
  assign is_ret   = (msg_type == MSG_SLOT_RETURN);
  assign is_load  = (msg_type == MSG_SLOT_LOAD);

  // load register frees up when the loader takes it
  assign load_free = !req.valid || req.ready;

  // other message types are swallowed
  assign ctrl_tready = is_ret ? ret_in_ready : (is_load ? load_free : 1'b1);

  // returns tagged with the reporting core
  sync_fifo #(
    .DEPTH_LOG2 (2),
    .WIDTH      (CORE_ID_WIDTH + SLOT_WIDTH)
  ) ret_fifo (
    .clk       (clk),
    .rst       (rst),
    .clear     (1'b0),
    .in_data   ({ctrl_tuser, field}),
    .in_valid  (ctrl_tvalid && is_ret),
    .in_ready  (ret_in_ready),
    .out_data  (ret_word),
    .out_valid (ret.valid),
    .out_ready (ret.ready),
    .count     ()
  );

  assign ret.core = ret_word[SLOT_WIDTH +: CORE_ID_WIDTH];
  assign ret.slot = ret_word[SLOT_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst)
      req.valid <= 1'b0;
    else if (load_free)
      req.valid <= ctrl_tvalid && is_load;
  end

  always_ff @(posedge clk) begin
    if (load_free && ctrl_tvalid && is_load) begin
      req.core  <= ctrl_tuser;
      req.count <= field;
    end
  end

endmodule

`default_nettype wire

// ==== slot_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_loader #(
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT)
) (
  input  logic       clk,
  input  logic       rst,

  load_req_if.sink   req,
  load_if.source     load
);

  typedef logic [SLOT_WIDTH-1:0] slot_t;
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CLEAR,
    ST_FILL
  } state_t;

  state_t                   state;
  logic [CORE_ID_WIDTH-1:0] core_r;
  slot_t                    last_r;
  slot_t                    slot_r;
  slot_t                    capped;

  // a core never gets more slots than its queue holds
  assign capped = (req.count > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : req.count;

  assign req.ready  = (state == ST_IDLE);
  assign load.clear = (state == ST_CLEAR);
  assign load.load  = (state == ST_FILL);
  assign load.core  = core_r;
  assign load.slot  = slot_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:
          if (req.valid)
            state <= ST_CLEAR;
        ST_CLEAR:
          // zero count only empties the queue
          state <= (last_r == '0) ? ST_IDLE : ST_FILL;
        ST_FILL:
          if (slot_r == last_r)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // slot counter walks 1..count
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req.valid) begin
      core_r <= req.core;
      last_r <= capped;
    end
    if (state == ST_CLEAR)
      slot_r <= slot_t'(1);
    else if (state == ST_FILL)
      slot_r <= slot_r + 1'b1;
  end

endmodule

`default_nettype wire

// ==== slot_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_pool #(
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int QUEUE_LOG2    = $clog2(SLOT_COUNT),
  localparam int COUNT_WIDTH   = QUEUE_LOG2 + 1
) (
  input  logic      clk,
  input  logic      rst,

  slot_ret_if.sink  ret,
  load_if.sink      load,
  desc_if.source    desc
);

  typedef logic [SLOT_WIDTH-1:0]  slot_t;
  typedef logic [COUNT_WIDTH-1:0] fill_t;

  logic [CORE_COUNT-1:0]    busy;
  logic [CORE_COUNT-1:0]    q_push;
  logic [CORE_COUNT-1:0]    q_pop;
  logic [CORE_COUNT-1:0]    q_clear;
  logic [CORE_COUNT-1:0]    q_ready;
  logic [CORE_COUNT-1:0]    q_valid;
  slot_t                    q_in [CORE_COUNT];
  slot_t                    q_head [CORE_COUNT];
  fill_t                    q_count [CORE_COUNT];
  logic                     ret_take;
  logic [CORE_ID_WIDTH-1:0] best_core;
  fill_t                    best_count;

  // slot 0 is taken off the return queue but never stored
  assign ret.ready = (q_ready[ret.core] || ret.slot == '0) && !busy[ret.core];
  assign ret_take  = ret.valid && ret.ready && (ret.slot != '0);

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
    assign busy[i]    = (load.clear || load.load) && (load.core == CORE_ID_WIDTH'(i));
    assign q_clear[i] = load.clear && (load.core == CORE_ID_WIDTH'(i));
    assign q_push[i]  = (load.load && (load.core == CORE_ID_WIDTH'(i))) ||
                        (ret_take && (ret.core == CORE_ID_WIDTH'(i)));
    assign q_in[i]    = busy[i] ? load.slot : ret.slot;
    assign q_pop[i]   = desc.pop && (best_core == CORE_ID_WIDTH'(i));

    sync_fifo #(
      .DEPTH_LOG2 (QUEUE_LOG2),
      .WIDTH      (SLOT_WIDTH)
    ) slot_queue (
      .clk       (clk),
      .rst       (rst),
      .clear     (q_clear[i]),
      .in_data   (q_in[i]),
      .in_valid  (q_push[i]),
      .in_ready  (q_ready[i]),
      .out_data  (q_head[i]),
      .out_valid (q_valid[i]),
      .out_ready (q_pop[i]),
      .count     (q_count[i])
    );
  end

  // most free slots, lowest index wins a tie
  always_comb begin
    best_core  = '0;
    best_count = q_count[0];
    for (int c = 1; c < CORE_COUNT; c++) begin
      if (q_count[c] > best_count) begin
        best_core  = CORE_ID_WIDTH'(c);
        best_count = q_count[c];
      end
    end
  end

  assign desc.valid = q_valid[best_core];
  assign desc.core  = best_core;
  assign desc.slot  = q_head[best_core];

endmodule

`default_nettype wire

// ==== port_tagger.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_tagger #(
  parameter int PORT_COUNT     = 2,
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH     = (SLOT_WIDTH > sched_pkg::TAG_MIN_WIDTH) ?
                                 SLOT_WIDTH : sched_pkg::TAG_MIN_WIDTH,
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH,
  localparam int PORT_ID_WIDTH = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1
) (
  input  logic                               clk,
  input  logic                               rst,

  desc_if.sink                               desc,

  input  logic [PORT_COUNT-1:0]              rx_tvalid,
  input  logic [PORT_COUNT-1:0]              rx_tlast,
  output logic [PORT_COUNT-1:0]              rx_tready,

  output logic [PORT_COUNT-1:0]              data_tvalid,
  input  logic [PORT_COUNT-1:0]              data_tready,
  output logic [PORT_COUNT*ID_TAG_WIDTH-1:0] data_tdest
);

  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [ID_TAG_WIDTH-1:0] id_tag_t;

  logic [PORT_COUNT-1:0]    tag_v;
  id_tag_t                  tag_r [PORT_COUNT];
  logic [PORT_COUNT-1:0]    last_xfer;
  logic [PORT_COUNT-1:0]    need;
  logic [PORT_ID_WIDTH-1:0] rr_ptr;
  logic [PORT_ID_WIDTH-1:0] grant;
  logic                     grant_v;

  // words only move while the port holds a tag
  assign rx_tready   = data_tready & tag_v;
  assign data_tvalid = rx_tvalid & tag_v;
  assign last_xfer   = rx_tvalid & rx_tlast & rx_tready;
  assign need        = ~tag_v | last_xfer;

  // first needy port at or after the pointer
  always_comb begin
    int idx;
    grant_v = 1'b0;
    grant   = '0;
    for (int k = 0; k < PORT_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % PORT_COUNT;
      if (!grant_v && need[idx]) begin
        grant_v = 1'b1;
        grant   = PORT_ID_WIDTH'(idx);
      end
    end
  end

  assign desc.pop = grant_v && desc.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_v  <= '0;
      rr_ptr <= '0;
    end else begin
      tag_v <= tag_v & ~last_xfer;
      if (desc.pop) begin
        tag_v[grant] <= 1'b1;
        rr_ptr       <= PORT_ID_WIDTH'((int'(grant) + 1) % PORT_COUNT);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (desc.pop)
      tag_r[grant] <= {desc.core, tag_t'(desc.slot)};
  end

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_dest
    assign data_tdest[p*ID_TAG_WIDTH +: ID_TAG_WIDTH] = tag_r[p];
  end

endmodule

`default_nettype wire

// ==== simple_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module simple_sched #(
  parameter int CORE_COUNT     = 16,
  parameter int SLOT_COUNT     = 8,
  parameter int PORT_COUNT     = 2,
  parameter int DATA_WIDTH     = 64,
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH     = (SLOT_WIDTH > sched_pkg::TAG_MIN_WIDTH) ?
                                 SLOT_WIDTH : sched_pkg::TAG_MIN_WIDTH,
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst,

  // control messages from the cores
  input  sched_pkg::ctrl_word_t              ctrl_tdata,
  input  logic [CORE_ID_WIDTH-1:0]           ctrl_tuser,
  input  logic                               ctrl_tvalid,
  output logic                               ctrl_tready,

  // ethernet receive ports
  input  logic [PORT_COUNT*DATA_WIDTH-1:0]   rx_tdata,
  input  logic [PORT_COUNT*KEEP_WIDTH-1:0]   rx_tkeep,
  input  logic [PORT_COUNT-1:0]              rx_tvalid,
  output logic [PORT_COUNT-1:0]              rx_tready,
  input  logic [PORT_COUNT-1:0]              rx_tlast,

  // tagged packets towards the cores
  output logic [PORT_COUNT*DATA_WIDTH-1:0]   data_tdata,
  output logic [PORT_COUNT*KEEP_WIDTH-1:0]   data_tkeep,
  output logic [PORT_COUNT-1:0]              data_tvalid,
  input  logic [PORT_COUNT-1:0]              data_tready,
  output logic [PORT_COUNT-1:0]              data_tlast,
  output logic [PORT_COUNT*ID_TAG_WIDTH-1:0] data_tdest
);

  slot_ret_if #(.CORE_ID_WIDTH(CORE_ID_WIDTH), .SLOT_WIDTH(SLOT_WIDTH)) ret_bus ();
  load_req_if #(.CORE_ID_WIDTH(CORE_ID_WIDTH), .SLOT_WIDTH(SLOT_WIDTH)) req_bus ();
  load_if     #(.CORE_ID_WIDTH(CORE_ID_WIDTH), .SLOT_WIDTH(SLOT_WIDTH)) load_bus ();
  desc_if     #(.CORE_ID_WIDTH(CORE_ID_WIDTH), .SLOT_WIDTH(SLOT_WIDTH)) desc_bus ();

  msg_intake #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) msg_intake_i (
    .clk         (clk),
    .rst         (rst),
    .ctrl_tdata  (ctrl_tdata),
    .ctrl_tuser  (ctrl_tuser),
    .ctrl_tvalid (ctrl_tvalid),
    .ctrl_tready (ctrl_tready),
    .ret         (ret_bus.source),
    .req         (req_bus.source)
  );

  slot_loader #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) slot_loader_i (
    .clk  (clk),
    .rst  (rst),
    .req  (req_bus.sink),
    .load (load_bus.source)
  );

  slot_pool #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) slot_pool_i (
    .clk  (clk),
    .rst  (rst),
    .ret  (ret_bus.sink),
    .load (load_bus.sink),
    .desc (desc_bus.source)
  );

  port_tagger #(
    .PORT_COUNT (PORT_COUNT),
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) port_tagger_i (
    .clk         (clk),
    .rst         (rst),
    .desc        (desc_bus.sink),
    .rx_tvalid   (rx_tvalid),
    .rx_tlast    (rx_tlast),
    .rx_tready   (rx_tready),
    .data_tvalid (data_tvalid),
    .data_tready (data_tready),
    .data_tdest  (data_tdest)
  );

  // payload is untouched, only valid and ready are gated
  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

endmodule

`default_nettype wire

// ==== tb_simple_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_simple_sched;

  import sched_pkg::*;

  localparam int CORE_COUNT    = 16;
  localparam int SLOT_COUNT    = 8;
  localparam int PORT_COUNT    = 2;
  localparam int DATA_WIDTH    = 64;
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int TAG_WIDTH     = (SLOT_WIDTH > TAG_MIN_WIDTH) ? SLOT_WIDTH : TAG_MIN_WIDTH;
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH;
  // one vector record is an opcode and five fields
  localparam int REC_LEN       = 6;
  localparam int MAX_RECORDS   = 128;
  localparam int CYCLES_PER_REC = 64;

  logic                               clk;
  logic                               rst;
  ctrl_word_t                         ctrl_tdata;
  logic [CORE_ID_WIDTH-1:0]           ctrl_tuser;
  logic                               ctrl_tvalid;
  logic                               ctrl_tready;
  logic [PORT_COUNT*DATA_WIDTH-1:0]   rx_tdata;
  logic [PORT_COUNT*KEEP_WIDTH-1:0]   rx_tkeep;
  logic [PORT_COUNT-1:0]              rx_tvalid;
  logic [PORT_COUNT-1:0]              rx_tready;
  logic [PORT_COUNT-1:0]              rx_tlast;
  logic [PORT_COUNT*DATA_WIDTH-1:0]   data_tdata;
  logic [PORT_COUNT*KEEP_WIDTH-1:0]   data_tkeep;
  logic [PORT_COUNT-1:0]              data_tvalid;
  logic [PORT_COUNT-1:0]              data_tready;
  logic [PORT_COUNT-1:0]              data_tlast;
  logic [PORT_COUNT*ID_TAG_WIDTH-1:0] data_tdest;

  logic [7:0] vec_mem [MAX_RECORDS*REC_LEN];
  int         cycle_count = 0;
  int         cycle_limit = 0;
  int         check_count = 0;
  int         error_count = 0;
  int         test_errors = 0;
  int         tests_done  = 0;
  int         test_num    = 0;
  logic       test_open   = 1'b0;

  simple_sched #(
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT),
    .PORT_COUNT (PORT_COUNT),
    .DATA_WIDTH (DATA_WIDTH)
  ) simple_sched_i (
    .clk         (clk),
    .rst         (rst),
    .ctrl_tdata  (ctrl_tdata),
    .ctrl_tuser  (ctrl_tuser),
    .ctrl_tvalid (ctrl_tvalid),
    .ctrl_tready (ctrl_tready),
    .rx_tdata    (rx_tdata),
    .rx_tkeep    (rx_tkeep),
    .rx_tvalid   (rx_tvalid),
    .rx_tready   (rx_tready),
    .rx_tlast    (rx_tlast),
    .data_tdata  (data_tdata),
    .data_tkeep  (data_tkeep),
    .data_tvalid (data_tvalid),
    .data_tready (data_tready),
    .data_tlast  (data_tlast),
    .data_tdest  (data_tdest)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one stall pattern for all ports keeps ports started together in lockstep
  initial begin
    data_tready = '1;
    void'($urandom(26));
    forever begin
      @(posedge clk);
      #1;
      data_tready = (($urandom % 4) == 0) ? '0 : '1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never finished the vectors", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [DATA_WIDTH-1:0] word_value(input int pkt, input int idx);
    return {8'ha5, 24'(pkt), 32'(idx)};
  endfunction

  // partial byte enables only on the last word of a packet
  function automatic logic [KEEP_WIDTH-1:0] keep_value(input int pkt, input bit last);
    return last ? ({KEEP_WIDTH{1'b1}} >> (pkt % KEEP_WIDTH)) : '1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (test_open) begin
      $display("test %0d finished with %0d errors", test_num, test_errors);
      tests_done++;
      test_open = 1'b0;
    end
  endtask

  task automatic send_ctrl(input int msg_type, input int core, input int field);
    logic accepted;
    accepted = 1'b0;
    ctrl_tdata = '0;
    ctrl_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH] = MSG_TYPE_WIDTH'(msg_type);
    ctrl_tdata[SLOT_FIELD_LSB +: SLOT_WIDTH] = SLOT_WIDTH'(field);
    ctrl_tuser = CORE_ID_WIDTH'(core);
    ctrl_tvalid = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = ctrl_tready;
      @(posedge clk);
      #1;
    end
    ctrl_tvalid = 1'b0;
  endtask

  // nothing may pass before a tag is loaded
  task automatic check_blocked(input int cycles);
    rx_tvalid = '1;
    repeat (cycles) begin
      @(negedge clk);
      check_value("data_tvalid", 64'(data_tvalid), 64'd0);
      check_value("rx_tready", 64'(rx_tready), 64'd0);
      @(posedge clk);
      #1;
    end
    rx_tvalid = '0;
  endtask

  task automatic send_packet(input int port, input int len, input int core, input int slot,
                             input int pkt);
    int                      sent;
    logic [DATA_WIDTH-1:0]   word;
    logic [KEEP_WIDTH-1:0]   keep;
    logic [ID_TAG_WIDTH-1:0] exp_dest;
    sent = 0;
    exp_dest = {CORE_ID_WIDTH'(core), TAG_WIDTH'(slot)};
    while (sent < len) begin
      word = word_value(pkt, sent);
      keep = keep_value(pkt, sent == len - 1);
      rx_tdata[port*DATA_WIDTH +: DATA_WIDTH] = word;
      rx_tkeep[port*KEEP_WIDTH +: KEEP_WIDTH] = keep;
      rx_tlast[port] = (sent == len - 1);
      rx_tvalid[port] = 1'b1;
      @(negedge clk);
      // word moves on the coming edge
      if (rx_tready[port]) begin
        check_value($sformatf("data_tvalid[%0d]", port), 64'(data_tvalid[port]), 64'd1);
        check_value($sformatf("data_tdest[%0d]", port),
                    64'(data_tdest[port*ID_TAG_WIDTH +: ID_TAG_WIDTH]), 64'(exp_dest));
        check_value($sformatf("data_tdata[%0d]", port),
                    64'(data_tdata[port*DATA_WIDTH +: DATA_WIDTH]), 64'(word));
        check_value($sformatf("data_tkeep[%0d]", port),
                    64'(data_tkeep[port*KEEP_WIDTH +: KEEP_WIDTH]), 64'(keep));
        check_value($sformatf("data_tlast[%0d]", port), 64'(data_tlast[port]),
                    64'(sent == len - 1));
        sent++;
      end
      @(posedge clk);
      #1;
    end
    rx_tvalid[port] = 1'b0;
    rx_tlast[port] = 1'b0;
  endtask

  initial begin
    int rec;
    int record_count;
    int packet_id;
    int f [REC_LEN];
    rst = 1'b1;
    ctrl_tdata = '0;
    ctrl_tuser = '0;
    ctrl_tvalid = 1'b0;
    rx_tdata = '0;
    rx_tkeep = '0;
    rx_tvalid = '0;
    rx_tlast = '0;
    packet_id = 0;
    record_count = 0;
    $readmemh("sched_vectors.txt", vec_mem);
    while (record_count < MAX_RECORDS && vec_mem[record_count*REC_LEN] != 8'h00)
      record_count++;
    cycle_limit = record_count * CYCLES_PER_REC;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    for (rec = 0; rec < record_count; rec++) begin
      for (int k = 0; k < REC_LEN; k++)
        f[k] = int'(vec_mem[rec*REC_LEN + k]);
      case (f[0])
        1: begin
          finish_test();
          test_num = f[1];
          test_errors = 0;
          test_open = 1'b1;
        end
        2: send_ctrl(f[1], f[2], f[3]);
        3: begin
          send_packet(f[1], f[2], f[3], f[4], packet_id);
          packet_id++;
        end
        4: begin
          repeat (f[1]) @(posedge clk);
          #1;
        end
        5: check_blocked(f[1]);
        6: begin
          fork
            send_packet(0, f[1], f[2], f[3], packet_id);
            send_packet(1, f[1], f[4], f[5], packet_id + 1);
          join
          packet_id += 2;
        end
        default: begin
          $display("unknown vector operation %0d in record %0d", f[0], rec);
          error_count++;
        end
      endcase
    end
    finish_test();

    if (tests_done == 0) begin
      $display("no test vectors could be read from sched_vectors.txt");
      error_count++;
    end
    $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sched_vectors.txt ====
// op f1 f2 f3 f4 f5 in hex, 0 end, 1 test (num), 2 ctrl (type core field), 4 idle (cycles)
// 3 packet (port len core slot), 5 blocked ports (cycles), 6 both ports (len c0 s0 c1 s1)
01 01 00 00 00 00
05 14 00 00 00 00
// load core 2 with 3 slots, ports prefetch in round-robin order
01 02 00 00 00 00
02 03 02 03 00 00
04 14 00 00 00 00
03 00 03 02 01 00
03 01 02 02 02 00
03 00 01 02 03 00
// ports hold core 5 tags while cores 0 and 1 fill up
01 03 00 00 00 00
02 03 05 02 00 00
04 14 00 00 00 00
02 03 00 02 00 00
02 03 01 04 00 00
04 18 00 00 00 00
03 01 02 05 01 00
03 00 03 05 02 00
03 01 01 01 01 00
03 00 02 01 02 00
03 01 03 00 01 00
03 00 01 01 03 00
03 01 02 00 02 00
03 00 04 01 04 00
// slot 0 return and a type 1 message leave the queues untouched
01 04 00 00 00 00
02 00 07 00 00 00
02 01 02 04 00 00
04 10 00 00 00 00
02 00 03 05 00 00
04 10 00 00 00 00
03 01 03 03 05 00
// both ports at once, refetch order follows the round-robin pointer
01 05 00 00 00 00
02 03 04 02 00 00
04 14 00 00 00 00
02 03 06 01 00 00
02 03 08 03 00 00
04 18 00 00 00 00
06 04 04 01 04 02
04 04 00 00 00 00
06 03 08 01 08 02
04 04 00 00 00 00
06 02 06 01 08 03
00 00 00 00 00 00

// ==== list.f ====
sched_pkg.sv
sched_if.sv
sync_fifo.sv
msg_intake.sv
slot_loader.sv
slot_pool.sv
port_tagger.sv
simple_sched.sv
tb_simple_sched.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, then scan the log for the fail message
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module tb_simple_sched \
  -o tb_simple_sched > sim.log 2>&1 \
  && ./obj_dir/tb_simple_sched >> sim.log 2>&1 \
  || echo "Something failed" >> sim.log
if grep -q "Something failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"
exit 0
